// File: list.f
common/excp_pkg.sv
rtl/irq_ctrl.sv
rtl/wfi_ctrl.sv
trap/trap_arbiter.sv
trap/trap_csr.sv
rtl/excp_top.sv
verif/excp_assert.sv
verif/tb_excp.sv

// File: Bender.yml
package:
  name: excp_unit

sources:
  - common/excp_pkg.sv
  - rtl/irq_ctrl.sv
  - rtl/wfi_ctrl.sv
  - trap/trap_arbiter.sv
  - trap/trap_csr.sv
  - rtl/excp_top.sv
  - target: simulation
    files:
      - verif/excp_assert.sv
      - verif/tb_excp.sv

// File: verif/tb_excp.sv
`timescale 1ns/1ps
`default_nettype none

module tb_excp;

  import excp_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 5;
  // About four times the ~450 stimulus cycles of all sequences
  localparam int MAX_CYCLES = 2000;

  logic  clk = 1'b0;
  logic  arst_n;
  logic  cmt_ena, oitf_empty, amo_wait;
  priv_t priv;
  logic  alu_valid, alu_pc_valid, alu_ld, alu_stamo, alu_misalgn, alu_buserr;
  logic  alu_ecall, alu_ebreak, alu_wfi, alu_ifu_misalgn, alu_ifu_buserr, alu_ifu_ilegl;
  xlen_t alu_pc, alu_instr, alu_badaddr;
  logic  longp_valid, longp_ld, longp_st, longp_buserr, longp_insterr;
  xlen_t longp_pc, longp_badaddr;
  logic  ext_irq, sft_irq, tmr_irq, meie, msie, mtie, mie_r;
  logic  flush_ack, halt_ifu_ack, halt_exu_ack;
  logic  alu_ready, longp_ready, flush_req, flush_req_raw, commit_trap;
  xlen_t cmt_cause, cmt_epc, cmt_badaddr;
  logic  epc_ena, cause_ena, status_ena, badaddr_ena;
  logic  halt_ifu_req, halt_exu_req, core_wfi, excp_active;

  // Expected combinational outputs for one cycle
  typedef struct packed {
    logic  flush_req;
    logic  flush_req_raw;
    logic  alu_ready;
    logic  longp_ready;
    logic  commit_trap;
    logic  ena;
    xlen_t cause;
    xlen_t epc;
    xlen_t badaddr;
  } expect_t;

  logic [31:0] lfsr_state;
  int unsigned check_count = 0;
  int unsigned error_count = 0;
  int unsigned cycle_count = 0;
  int unsigned total_errors;

  excp_top u_excp_top (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Random source and checking
  //////////////////////////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic check_value(input string what, input xlen_t got, input xlen_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] t=%0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic expect_t model_trap();
    expect_t    e;
    logic       sft;
    logic       tmr;
    logic       ext;
    logic       irq;
    logic       alu_fault;
    logic [4:0] code;
    e   = '0;
    sft = sft_irq & msie;
    tmr = tmr_irq & mtie;
    ext = ext_irq & meie;
    // Pending interrupt needs global enable and no AMO in flight
    irq = (sft | tmr | ext) & mie_r & ~amo_wait;
    alu_fault = alu_misalgn | alu_buserr | alu_ecall | alu_ebreak
              | alu_ifu_misalgn | alu_ifu_buserr | alu_ifu_ilegl;
    e.longp_ready   = flush_ack;
    e.flush_req_raw = longp_valid | irq;
    if (alu_fault) begin
      e.alu_ready = flush_ack & oitf_empty & ~irq & ~longp_valid;
    end else begin
      e.alu_ready = ~irq & ~longp_valid;
    end
    e.epc = longp_valid ? longp_pc : alu_pc;
    if (longp_valid) begin
      e.flush_req = 1'b1;
      case (1'b1)
        longp_ld & longp_buserr: code = CAUSE_LD_BUSERR;
        longp_st & longp_buserr: code = CAUSE_ST_BUSERR;
        longp_insterr:           code = CAUSE_LONGP_INSTERR;
        default:                 code = CAUSE_RESERVED;
      endcase
      e.cause = xlen_t'(code);
      if ((longp_ld | longp_st) & longp_buserr) begin
        e.badaddr = longp_badaddr;
      end
    end else if (irq & oitf_empty & alu_pc_valid) begin
      e.flush_req = 1'b1;
      e.cause[XLEN-1] = 1'b1;
      e.cause[3:0] = sft ? IRQ_SOFT : (tmr ? IRQ_TIMER : IRQ_EXT);
    end else if (~irq & alu_valid & alu_fault & oitf_empty) begin
      e.flush_req = 1'b1;
      // First match in cause code order
      case (1'b1)
        alu_ifu_misalgn:         code = CAUSE_IFU_MISALGN;
        alu_ifu_buserr:          code = CAUSE_IFU_BUSERR;
        alu_ifu_ilegl:           code = CAUSE_ILLEGAL;
        alu_ebreak:              code = CAUSE_BREAKPOINT;
        alu_ld & alu_misalgn:    code = CAUSE_LD_MISALGN;
        alu_ld & alu_buserr:     code = CAUSE_LD_BUSERR;
        alu_stamo & alu_misalgn: code = CAUSE_ST_MISALGN;
        alu_stamo & alu_buserr:  code = CAUSE_ST_BUSERR;
        alu_ecall:               code = CAUSE_ECALL_BASE + {3'b000, priv};
        default:                 code = CAUSE_RESERVED;
      endcase
      e.cause = xlen_t'(code);
      case (1'b1)
        (alu_ld | alu_stamo) & (alu_misalgn | alu_buserr): e.badaddr = alu_badaddr;
        alu_ebreak | alu_ifu_misalgn | alu_ifu_buserr:     e.badaddr = alu_pc;
        alu_ifu_ilegl:                                      e.badaddr = alu_instr;
        default:                                            e.badaddr = '0;
      endcase
    end
    e.commit_trap = e.flush_req & flush_ack;
    e.ena         = e.commit_trap;
    return e;
  endfunction

  // Compare at mid-cycle once the inputs have settled
  always @(negedge clk) begin : compare_outputs
    expect_t e;
    if (arst_n) begin
      e = model_trap();
      check_value("flush_req", flush_req, e.flush_req);
      check_value("flush_req_raw", flush_req_raw, e.flush_req_raw);
      check_value("alu_ready", alu_ready, e.alu_ready);
      check_value("longp_ready", longp_ready, e.longp_ready);
      check_value("commit_trap", commit_trap, e.commit_trap);
      check_value("epc_ena", epc_ena, e.ena);
      check_value("cause_ena", cause_ena, e.ena);
      check_value("status_ena", status_ena, e.ena);
      check_value("badaddr_ena", badaddr_ena, e.ena);
      if (e.ena) begin
        check_value("cmt_cause", cmt_cause, e.cause);
        check_value("cmt_epc", cmt_epc, e.epc);
        check_value("cmt_badaddr", cmt_badaddr, e.badaddr);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  task automatic next_drive();
    @(posedge clk);
    #2;
  endtask

  task automatic idle_inputs();
    {cmt_ena, oitf_empty, amo_wait, alu_valid, alu_pc_valid, alu_ld, alu_stamo} = '0;
    {alu_misalgn, alu_buserr, alu_ecall, alu_ebreak, alu_wfi} = '0;
    {alu_ifu_misalgn, alu_ifu_buserr, alu_ifu_ilegl} = '0;
    {longp_valid, longp_ld, longp_st, longp_buserr, longp_insterr} = '0;
    {ext_irq, sft_irq, tmr_irq, meie, msie, mtie, mie_r} = '0;
    {flush_ack, halt_ifu_ack, halt_exu_ack} = '0;
    priv          = PRIV_U;
    alu_pc        = '0;
    alu_instr     = '0;
    alu_badaddr   = '0;
    longp_pc      = '0;
    longp_badaddr = '0;
  endtask

  task automatic rand_longp();
    logic [31:0] r;
    rand_bits(2, r);
    // Kind 0 load bus error, 1 store bus error, 2 insterr, 3 nothing flagged
    longp_ld      = (r[1:0] == 2'd0);
    longp_st      = (r[1:0] == 2'd1);
    longp_buserr  = (r[1:0] < 2'd2);
    longp_insterr = (r[1:0] == 2'd2);
    rand_bits(32, r);
    longp_pc = r;
    rand_bits(32, r);
    longp_badaddr = r;
  endtask

  task automatic rand_irq();
    logic [31:0] r;
    rand_bits(10, r);
    {ext_irq, sft_irq, tmr_irq, meie, msie, mtie} = r[5:0];
    // Global enable mostly on, AMO wait mostly off
    mie_r    = r[6] | r[7];
    amo_wait = r[8] & r[9];
  endtask

  task automatic rand_alu(input logic faults);
    logic [31:0] r;
    rand_bits(28, r);
    // Each fault flag at 1 in 8 so the later causes still show up
    alu_misalgn     = faults & (r[2:0] == 3'd0);
    alu_buserr      = faults & (r[5:3] == 3'd0);
    alu_ecall       = faults & (r[8:6] == 3'd0);
    alu_ebreak      = faults & (r[11:9] == 3'd0);
    alu_ifu_misalgn = faults & (r[14:12] == 3'd0);
    alu_ifu_buserr  = faults & (r[17:15] == 3'd0);
    alu_ifu_ilegl   = faults & (r[20:18] == 3'd0);
    {alu_ld, alu_stamo} = r[22:21];
    alu_valid    = r[23] | r[24];
    alu_pc_valid = r[25];
    priv         = r[27:26];
    rand_bits(32, r);
    alu_pc = r;
    rand_bits(32, r);
    alu_instr = r;
    rand_bits(32, r);
    alu_badaddr = r;
  endtask

  task automatic rand_pipe();
    logic [31:0] r;
    rand_bits(3, r);
    oitf_empty = r[0] | r[1];
    flush_ack  = r[2];
  endtask

  // Hold the request with a random flush_ack until the trap is taken
  task automatic wait_taken();
    logic [31:0] r;
    logic        taken;
    taken = 1'b0;
    while (!taken) begin
      rand_bits(1, r);
      flush_ack = r[0];
      @(negedge clk);
      taken = commit_trap;
      if (!taken) begin
        next_drive();
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequences
  //////////////////////////////////////////////////////////////////////

  task automatic run_longp(input int count);
    for (int n = 0; n < count; n++) begin
      next_drive();
      idle_inputs();
      rand_longp();
      rand_pipe();
      longp_valid = 1'b1;
      wait_taken();
    end
  endtask

  task automatic run_random(input int count, input logic irq_on, input logic faults,
                            input logic longp_on);
    logic [31:0] r;
    next_drive();
    idle_inputs();
    for (int n = 0; n < count; n++) begin
      if (n != 0) begin
        next_drive();
      end
      if (irq_on) begin
        rand_irq();
      end
      if (longp_on) begin
        rand_longp();
        rand_bits(2, r);
        longp_valid = (r[1:0] == 2'd0);
      end
      rand_alu(faults);
      rand_pipe();
    end
  endtask

  // All three sources in the same cycle, then the two lower ones
  task automatic run_priority_directed();
    next_drive();
    idle_inputs();
    rand_longp();
    rand_alu(1'b0);
    {longp_valid, sft_irq, msie, mie_r, alu_valid, alu_ecall} = '1;
    {alu_pc_valid, oitf_empty, flush_ack} = '1;
    @(negedge clk);
    check_value("long-pipe wins over interrupt", cmt_cause[XLEN-1], 1'b0);
    next_drive();
    longp_valid = 1'b0;
    @(negedge clk);
    check_value("interrupt wins over ALU", cmt_cause[XLEN-1], 1'b1);
    check_value("interrupt taken", commit_trap, 1'b1);
    // Awake core shows the pending interrupt
    check_value("excp_active on interrupt", excp_active, 1'b1);
  endtask

  task automatic run_wfi();
    next_drive();
    idle_inputs();
    {cmt_ena, alu_valid, alu_wfi} = '1;
    @(negedge clk);
    check_value("halt_ifu_req before wfi edge", halt_ifu_req, 1'b0);
    next_drive();
    {cmt_ena, alu_valid, alu_wfi} = '0;
    @(negedge clk);
    check_value("halt_ifu_req after wfi", halt_ifu_req, 1'b1);
    check_value("halt_exu_req after wfi", halt_exu_req, 1'b1);
    check_value("core_wfi before acks", core_wfi, 1'b0);
    next_drive();
    {halt_ifu_ack, halt_exu_ack} = '1;
    @(negedge clk);
    check_value("core_wfi in ack cycle", core_wfi, 1'b0);
    next_drive();
    @(negedge clk);
    check_value("core_wfi while asleep", core_wfi, 1'b1);
    check_value("excp_active while asleep", excp_active, 1'b0);
    // Enabled timer wakes the core even with mie_r low
    next_drive();
    {tmr_irq, mtie} = '1;
    @(negedge clk);
    check_value("core_wfi on wake", core_wfi, 1'b0);
    check_value("halt_ifu_req on wake", halt_ifu_req, 1'b0);
    check_value("halt_exu_req on wake", halt_exu_req, 1'b1);
    check_value("excp_active on wake", excp_active, 1'b1);
    next_drive();
    @(negedge clk);
    check_value("halt_exu_req after wake", halt_exu_req, 1'b0);
    check_value("core_wfi after wake", core_wfi, 1'b0);
    // Awake again so the masked interrupt no longer counts
    check_value("excp_active after wake", excp_active, 1'b0);
  endtask

  initial begin
    lfsr_state = 32'h9413;
    arst_n = 1'b0;
    idle_inputs();
    repeat (RST_CYCLES) @(posedge clk);
    #2;
    arst_n = 1'b1;
    run_longp(30);
    // Interrupts over a clean ALU stream
    run_random(80, 1'b1, 1'b0, 1'b0);
    // ALU exceptions alone
    run_random(150, 1'b0, 1'b1, 1'b0);
    // All sources mixed
    run_random(80, 1'b1, 1'b1, 1'b1);
    run_priority_directed();
    run_wfi();
    next_drive();
    idle_inputs();
    @(negedge clk);
    total_errors = error_count + u_excp_top.u_excp_assert.assert_errors;
    $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
             check_count, error_count, u_excp_top.u_excp_assert.assert_errors);
    if (total_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/excp_assert.sv
`timescale 1ns/1ps
`default_nettype none

module excp_assert (
  input logic clk,
  input logic arst_n,
  input logic commit_trap,
  input logic flush_req,
  input logic flush_ack,
  input logic halt_ifu_req,
  input logic halt_exu_req,
  input logic core_wfi,
  input logic alu_ready,
  input logic longp_valid
);

  // Failed assertion count, summed into the testbench result
  int unsigned assert_errors = 0;

  // Trap taken only on a full flush handshake
  a_commit_handshake : assert property (
    @(posedge clk) disable iff (!arst_n)
    commit_trap |-> (flush_req && flush_ack)
  ) else begin
    assert_errors++;
    $error("commit_trap seen without flush_req and flush_ack");
  end

  // Fetch halt never runs ahead of the execute halt
  a_halt_order : assert property (
    @(posedge clk) disable iff (!arst_n)
    halt_ifu_req |-> halt_exu_req
  ) else begin
    assert_errors++;
    $error("halt_ifu_req high while halt_exu_req is low");
  end

  // Core leaves reset awake
  a_wfi_reset : assert property (
    @(posedge clk)
    $rose(arst_n) |-> !core_wfi
  ) else begin
    assert_errors++;
    $error("core_wfi high when reset is released");
  end

  // Long-pipe exception blocks ALU commit
  a_longp_block : assert property (
    @(posedge clk) disable iff (!arst_n)
    longp_valid |-> !alu_ready
  ) else begin
    assert_errors++;
    $error("alu_ready high during a long-pipe exception");
  end

endmodule

bind excp_top excp_assert u_excp_assert (
  .clk          (clk),
  .arst_n       (arst_n),
  .commit_trap  (commit_trap),
  .flush_req    (flush_req),
  .flush_ack    (flush_ack),
  .halt_ifu_req (halt_ifu_req),
  .halt_exu_req (halt_exu_req),
  .core_wfi     (core_wfi),
  .alu_ready    (alu_ready),
  .longp_valid  (longp_valid)
);

`default_nettype wire

// File: rtl/excp_top.sv
`timescale 1ns/1ps
`default_nettype none

module excp_top (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            cmt_ena,
  input  logic            oitf_empty,
  input  logic            amo_wait,
  input  excp_pkg::priv_t priv,
  // ALU commit source
  input  logic            alu_valid,
  input  logic            alu_pc_valid,
  input  logic            alu_ld,
  input  logic            alu_stamo,
  input  logic            alu_misalgn,
  input  logic            alu_buserr,
  input  logic            alu_ecall,
  input  logic            alu_ebreak,
  input  logic            alu_wfi,
  input  logic            alu_ifu_misalgn,
  input  logic            alu_ifu_buserr,
  input  logic            alu_ifu_ilegl,
  input  excp_pkg::xlen_t alu_pc,
  input  excp_pkg::xlen_t alu_instr,
  input  excp_pkg::xlen_t alu_badaddr,
  // Long-pipe source
  input  logic            longp_valid,
  input  logic            longp_ld,
  input  logic            longp_st,
  input  logic            longp_buserr,
  input  logic            longp_insterr,
  input  excp_pkg::xlen_t longp_pc,
  input  excp_pkg::xlen_t longp_badaddr,
  // Interrupt sources and enables
  input  logic            ext_irq,
  input  logic            sft_irq,
  input  logic            tmr_irq,
  input  logic            meie,
  input  logic            msie,
  input  logic            mtie,
  input  logic            mie_r,
  // Flush and halt handshakes
  input  logic            flush_ack,
  input  logic            halt_ifu_ack,
  input  logic            halt_exu_ack,
  output logic            alu_ready,
  output logic            longp_ready,
  output logic            flush_req,
  output logic            flush_req_raw,
  output logic            commit_trap,
  // CSR update
  output excp_pkg::xlen_t cmt_cause,
  output excp_pkg::xlen_t cmt_epc,
  output excp_pkg::xlen_t cmt_badaddr,
  output logic            epc_ena,
  output logic            cause_ena,
  output logic            status_ena,
  output logic            badaddr_ena,
  // Sleep
  output logic            halt_ifu_req,
  output logic            halt_exu_req,
  output logic            core_wfi,
  output logic            excp_active
);

  import excp_pkg::*;

  logic  irq_req;
  logic  wake_req;
  logic  sleeping;
  logic  alu_excp_sel;
  logic  excp_taken;
  logic  irq_taken;
  xlen_t irq_cause;

  //////////////////////////////////////////////////////////////////////
  // Interrupt masking and sleep control
  //////////////////////////////////////////////////////////////////////

  irq_ctrl u_irq_ctrl (
    .ext_irq     (ext_irq),
    .sft_irq     (sft_irq),
    .tmr_irq     (tmr_irq),
    .meie        (meie),
    .msie        (msie),
    .mtie        (mtie),
    .mie_r       (mie_r),
    .amo_wait    (amo_wait),
    .sleeping    (sleeping),
    .irq_req     (irq_req),
    .wake_req    (wake_req),
    .excp_active (excp_active),
    .irq_cause   (irq_cause)
  );

  // Halt starts from a committed wfi
  wfi_ctrl u_wfi_ctrl (
    .clk          (clk),
    .arst_n       (arst_n),
    .wfi_commit   (cmt_ena & alu_wfi),
    .wake_req     (wake_req),
    .halt_ifu_ack (halt_ifu_ack),
    .halt_exu_ack (halt_exu_ack),
    .halt_ifu_req (halt_ifu_req),
    .halt_exu_req (halt_exu_req),
    .core_wfi     (core_wfi),
    .sleeping     (sleeping)
  );

  //////////////////////////////////////////////////////////////////////
  // Trap selection and CSR values
  //////////////////////////////////////////////////////////////////////

  trap_arbiter u_trap_arbiter (
    .alu_misalgn     (alu_misalgn),
    .alu_buserr      (alu_buserr),
    .alu_ecall       (alu_ecall),
    .alu_ebreak      (alu_ebreak),
    .alu_ifu_misalgn (alu_ifu_misalgn),
    .alu_ifu_buserr  (alu_ifu_buserr),
    .alu_ifu_ilegl   (alu_ifu_ilegl),
    .alu_valid       (alu_valid),
    .alu_pc_valid    (alu_pc_valid),
    .longp_valid     (longp_valid),
    .oitf_empty      (oitf_empty),
    .irq_req         (irq_req),
    .flush_ack       (flush_ack),
    .alu_ready       (alu_ready),
    .longp_ready     (longp_ready),
    .flush_req       (flush_req),
    .flush_req_raw   (flush_req_raw),
    .commit_trap     (commit_trap),
    .alu_excp_sel    (alu_excp_sel),
    .excp_taken      (excp_taken),
    .irq_taken       (irq_taken)
  );

  trap_csr u_trap_csr (
    .alu_excp_sel    (alu_excp_sel),
    .excp_taken      (excp_taken),
    .irq_taken       (irq_taken),
    .priv            (priv),
    .alu_ld          (alu_ld),
    .alu_stamo       (alu_stamo),
    .alu_misalgn     (alu_misalgn),
    .alu_buserr      (alu_buserr),
    .alu_ecall       (alu_ecall),
    .alu_ebreak      (alu_ebreak),
    .alu_ifu_misalgn (alu_ifu_misalgn),
    .alu_ifu_buserr  (alu_ifu_buserr),
    .alu_ifu_ilegl   (alu_ifu_ilegl),
    .longp_valid     (longp_valid),
    .longp_ld        (longp_ld),
    .longp_st        (longp_st),
    .longp_buserr    (longp_buserr),
    .longp_insterr   (longp_insterr),
    .alu_pc          (alu_pc),
    .alu_instr       (alu_instr),
    .alu_badaddr     (alu_badaddr),
    .longp_pc        (longp_pc),
    .longp_badaddr   (longp_badaddr),
    .irq_cause       (irq_cause),
    .cmt_cause       (cmt_cause),
    .cmt_epc         (cmt_epc),
    .cmt_badaddr     (cmt_badaddr),
    .epc_ena         (epc_ena),
    .cause_ena       (cause_ena),
    .status_ena      (status_ena),
    .badaddr_ena     (badaddr_ena)
  );

endmodule

`default_nettype wire

// File: trap/trap_csr.sv
`timescale 1ns/1ps
`default_nettype none

module trap_csr (
  input  logic            alu_excp_sel,
  input  logic            excp_taken,
  input  logic            irq_taken,
  input  excp_pkg::priv_t priv,
  input  logic            alu_ld,
  input  logic            alu_stamo,
  input  logic            alu_misalgn,
  input  logic            alu_buserr,
  input  logic            alu_ecall,
  input  logic            alu_ebreak,
  input  logic            alu_ifu_misalgn,
  input  logic            alu_ifu_buserr,
  input  logic            alu_ifu_ilegl,
  input  logic            longp_valid,
  input  logic            longp_ld,
  input  logic            longp_st,
  input  logic            longp_buserr,
  input  logic            longp_insterr,
  input  excp_pkg::xlen_t alu_pc,
  input  excp_pkg::xlen_t alu_instr,
  input  excp_pkg::xlen_t alu_badaddr,
  input  excp_pkg::xlen_t longp_pc,
  input  excp_pkg::xlen_t longp_badaddr,
  input  excp_pkg::xlen_t irq_cause,
  output excp_pkg::xlen_t cmt_cause,
  output excp_pkg::xlen_t cmt_epc,
  output excp_pkg::xlen_t cmt_badaddr,
  output logic            epc_ena,
  output logic            cause_ena,
  output logic            status_ena,
  output logic            badaddr_ena
);

  import excp_pkg::*;

  logic       ld_misalgn;
  logic       st_misalgn;
  logic       ld_buserr;
  logic       st_buserr;
  logic       alu_agu;
  logic       longp_ldst;
  logic       pc_fault;
  logic [4:0] excp_code;

  //////////////////////////////////////////////////////////////////////
  // Qualified fault terms
  //////////////////////////////////////////////////////////////////////

  // ALU flags count only when the ALU is the chosen source
  assign ld_misalgn = alu_excp_sel & alu_ld & alu_misalgn;
  assign st_misalgn = alu_excp_sel & alu_stamo & alu_misalgn;

  // Bus errors merge ALU and long-pipe
  assign ld_buserr = (alu_excp_sel & alu_ld & alu_buserr)
                   | (longp_valid & longp_ld & longp_buserr);
  assign st_buserr = (alu_excp_sel & alu_stamo & alu_buserr)
                   | (longp_valid & longp_st & longp_buserr);

  assign alu_agu    = alu_excp_sel & (alu_ld | alu_stamo) & (alu_misalgn | alu_buserr);
  assign longp_ldst = longp_valid & (longp_ld | longp_st) & longp_buserr;
  assign pc_fault   = alu_excp_sel & (alu_ebreak | alu_ifu_misalgn | alu_ifu_buserr);

  //////////////////////////////////////////////////////////////////////
  // mcause
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (alu_excp_sel & alu_ifu_misalgn) begin
      excp_code = CAUSE_IFU_MISALGN;
    end else if (alu_excp_sel & alu_ifu_buserr) begin
      excp_code = CAUSE_IFU_BUSERR;
    end else if (alu_excp_sel & alu_ifu_ilegl) begin
      excp_code = CAUSE_ILLEGAL;
    end else if (alu_excp_sel & alu_ebreak) begin
      excp_code = CAUSE_BREAKPOINT;
    end else if (ld_misalgn) begin
      excp_code = CAUSE_LD_MISALGN;
    end else if (ld_buserr) begin
      excp_code = CAUSE_LD_BUSERR;
    end else if (st_misalgn) begin
      excp_code = CAUSE_ST_MISALGN;
    end else if (st_buserr) begin
      excp_code = CAUSE_ST_BUSERR;
    end else if (alu_excp_sel & alu_ecall) begin
      // 8 for U up to 11 for M
      excp_code = CAUSE_ECALL_BASE + {3'b000, priv};
    end else if (longp_valid & longp_insterr) begin
      excp_code = CAUSE_LONGP_INSTERR;
    end else begin
      excp_code = CAUSE_RESERVED;
    end
  end

  assign cmt_cause = excp_taken ? {{(XLEN-5){1'b0}}, excp_code} : irq_cause;

  //////////////////////////////////////////////////////////////////////
  // mtval and mepc
  //////////////////////////////////////////////////////////////////////

  // Faulting address, PC or instruction bits, else zero
  always_comb begin
    if (longp_ldst) begin
      cmt_badaddr = longp_badaddr;
    end else if (alu_agu) begin
      cmt_badaddr = alu_badaddr;
    end else if (pc_fault) begin
      cmt_badaddr = alu_pc;
    end else if (alu_excp_sel & alu_ifu_ilegl) begin
      cmt_badaddr = alu_instr;
    end else begin
      cmt_badaddr = '0;
    end
  end

  // Long-pipe trap is imprecise and keeps its own PC
  assign cmt_epc = longp_valid ? longp_pc : alu_pc;

  // Every taken trap writes all four CSRs
  assign epc_ena     = excp_taken | irq_taken;
  assign cause_ena   = epc_ena;
  assign status_ena  = epc_ena;
  assign badaddr_ena = epc_ena;

endmodule

`default_nettype wire

// File: trap/trap_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module trap_arbiter (
  input  logic alu_misalgn,
  input  logic alu_buserr,
  input  logic alu_ecall,
  input  logic alu_ebreak,
  input  logic alu_ifu_misalgn,
  input  logic alu_ifu_buserr,
  input  logic alu_ifu_ilegl,
  input  logic alu_valid,
  input  logic alu_pc_valid,
  input  logic longp_valid,
  input  logic oitf_empty,
  input  logic irq_req,
  input  logic flush_ack,
  output logic alu_ready,
  output logic longp_ready,
  output logic flush_req,
  output logic flush_req_raw,
  output logic commit_trap,
  output logic alu_excp_sel,
  output logic excp_taken,
  output logic irq_taken
);

  logic alu_need_flush;
  logic longp_flush;
  logic irq_flush;
  logic alu_flush;
  logic higher_req;

  //////////////////////////////////////////////////////////////////////
  // Source requests
  //////////////////////////////////////////////////////////////////////

  // Ebreak is always a plain breakpoint here
  assign alu_need_flush = alu_misalgn | alu_buserr | alu_ecall | alu_ebreak
                        | alu_ifu_misalgn | alu_ifu_buserr | alu_ifu_ilegl;

  // Long-pipe always traps
  // No oitf or PC wait so it can never be stuck
  assign longp_flush = longp_valid;

  // Interrupt uses the next instruction PC for mepc
  // So it waits for a valid PC and an empty OITF
  assign irq_flush = irq_req & oitf_empty & alu_pc_valid & ~longp_valid;

  // ALU exception is the lowest priority
  assign alu_flush = alu_valid & alu_need_flush & oitf_empty
                   & ~irq_req & ~longp_valid;

  assign alu_excp_sel = alu_flush;

  //////////////////////////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////////////////////////

  assign flush_req = longp_flush | irq_flush | alu_flush;

  // Stop committing as soon as a higher source shows up
  assign higher_req    = irq_req | longp_valid;
  assign flush_req_raw = higher_req;

  assign longp_ready = flush_ack;

  // Excepting ALU instruction retires only with its own flush
  // A clean one is blocked only by a higher source
  always_comb begin
    if (alu_need_flush) begin
      alu_ready = flush_ack & oitf_empty & ~higher_req;
    end else begin
      alu_ready = ~higher_req;
    end
  end

  // Trap taken on the flush handshake
  assign commit_trap = flush_req & flush_ack;

  assign excp_taken = (longp_flush | alu_flush) & commit_trap;
  assign irq_taken  = irq_flush & commit_trap;

endmodule

`default_nettype wire

// File: rtl/wfi_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module wfi_ctrl (
  input  logic clk,
  input  logic arst_n,
  input  logic wfi_commit,
  input  logic wake_req,
  input  logic halt_ifu_ack,
  input  logic halt_exu_ack,
  output logic halt_ifu_req,
  output logic halt_exu_req,
  output logic core_wfi,
  output logic sleeping
);

  logic halt_r;
  logic halt_set;
  logic flag_set;

  //////////////////////////////////////////////////////////////////////
  // Halt request register
  //////////////////////////////////////////////////////////////////////

  // Set by a committed wfi, cleared by any wake request
  assign halt_set = wfi_commit;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      halt_r <= 1'b0;
    end else if (halt_set | wake_req) begin
      // Clear wins over a simultaneous set
      halt_r <= halt_set & ~wake_req;
    end
  end

  // Fetch halt qualified by the clear
  // Keeps the flush and the fetch halt out of the same cycle
  assign halt_ifu_req = halt_r & ~wake_req;

  // Execute halt left unqualified to avoid a comb loop
  // It drops one cycle after the fetch halt
  assign halt_exu_req = halt_r;

  //////////////////////////////////////////////////////////////////////
  // Sleep flag
  //////////////////////////////////////////////////////////////////////

  // Both halts handshaked in the same cycle
  assign flag_set = halt_ifu_req & halt_ifu_ack & halt_exu_req & halt_exu_ack;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sleeping <= 1'b0;
    end else if (flag_set | wake_req) begin
      sleeping <= flag_set & ~wake_req;
    end
  end

  // Drops in the wake cycle itself
  assign core_wfi = sleeping & ~wake_req;

endmodule

`default_nettype wire

// File: rtl/irq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl (
  input  logic            ext_irq,
  input  logic            sft_irq,
  input  logic            tmr_irq,
  input  logic            meie,
  input  logic            msie,
  input  logic            mtie,
  input  logic            mie_r,
  input  logic            amo_wait,
  input  logic            sleeping,
  output logic            irq_req,
  output logic            wake_req,
  output logic            excp_active,
  output excp_pkg::xlen_t irq_cause
);

  import excp_pkg::*;

  logic       ext_pend;
  logic       sft_pend;
  logic       tmr_pend;
  logic       any_pend;
  logic [3:0] irq_code;

  //////////////////////////////////////////////////////////////////////
  // Source masking
  //////////////////////////////////////////////////////////////////////

  // Each machine source qualified by its own enable bit in mie
  assign ext_pend = ext_irq & meie;
  assign sft_pend = sft_irq & msie;
  assign tmr_pend = tmr_irq & mtie;

  assign any_pend = ext_pend | sft_pend | tmr_pend;

  // Trap request needs the global enable
  // Held off during an AMO so the AMO can still commit
  assign irq_req = any_pend & mie_r & ~amo_wait;

  // Wake from sleep ignores both mie_r and amo_wait
  // A sleeping core has no AMO outstanding
  assign wake_req = any_pend;

  // Clock wake indication for the core clock gate
  assign excp_active = sleeping ? wake_req : irq_req;

  //////////////////////////////////////////////////////////////////////
  // Interrupt cause
  //////////////////////////////////////////////////////////////////////

  // Fixed priority soft, then timer, then external
  always_comb begin
    if (sft_pend) begin
      irq_code = IRQ_SOFT;
    end else if (tmr_pend) begin
      irq_code = IRQ_TIMER;
    end else if (ext_pend) begin
      irq_code = IRQ_EXT;
    end else begin
      irq_code = 4'd0;
    end
  end

  // Interrupt flag in the top bit, code in the low nibble
  assign irq_cause = {1'b1, {(XLEN-5){1'b0}}, irq_code};

endmodule

`default_nettype wire

// File: common/excp_pkg.sv
`default_nettype none

package excp_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and basic types
  //////////////////////////////////////////////////////////////////////

  // Data and address width
  // The mcause layout below depends on it
  localparam int unsigned XLEN = 32;

  // One data word for PCs, addresses, instructions and causes
  typedef logic [XLEN-1:0] xlen_t;

  // Encoded privilege level, same coding as mstatus.MPP
  typedef logic [1:0] priv_t;

  localparam priv_t PRIV_U = 2'd0;
  localparam priv_t PRIV_S = 2'd1;
  localparam priv_t PRIV_H = 2'd2;
  localparam priv_t PRIV_M = 2'd3;

  //////////////////////////////////////////////////////////////////////
  // Synchronous exception codes
  //////////////////////////////////////////////////////////////////////

  localparam logic [4:0] CAUSE_IFU_MISALGN   = 5'd0;
  localparam logic [4:0] CAUSE_IFU_BUSERR    = 5'd1;
  localparam logic [4:0] CAUSE_ILLEGAL       = 5'd2;
  localparam logic [4:0] CAUSE_BREAKPOINT    = 5'd3;
  localparam logic [4:0] CAUSE_LD_MISALGN    = 5'd4;
  localparam logic [4:0] CAUSE_LD_BUSERR     = 5'd5;
  localparam logic [4:0] CAUSE_ST_MISALGN    = 5'd6;
  localparam logic [4:0] CAUSE_ST_BUSERR     = 5'd7;
  // Ecall adds the current privilege to this base
  localparam logic [4:0] CAUSE_ECALL_BASE    = 5'd8;
  // Long-pipe instruction error
  localparam logic [4:0] CAUSE_LONGP_INSTERR = 5'd16;
  localparam logic [4:0] CAUSE_RESERVED      = 5'd31;

  //////////////////////////////////////////////////////////////////////
  // Machine interrupt codes
  //////////////////////////////////////////////////////////////////////

  // Interrupt causes also carry bit XLEN-1
  localparam logic [3:0] IRQ_SOFT  = 4'd3;
  localparam logic [3:0] IRQ_TIMER = 4'd7;
  localparam logic [3:0] IRQ_EXT   = 4'd11;

endpackage

`default_nettype wire
